// ==== Makefile ====
VERILATOR := verilator
FLAGS := --timing --assert
TOP := lcd_tb
FILELIST := verilog.f
OBJ_DIR := obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/lcd_bus_drive.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_drive (
	input wire logic clk,
	input wire logic rst,
	input wire logic load,
	input wire lcd_bus_pkg::lcd_cmd_t cmd,
	input wire logic e,
	input wire logic [7:0] lcd_data_in,
	output lcd_bus_pkg::lcd_pins_t pins,
	output logic data_oe,
	output logic rd_valid,
	output logic [7:0] rd_data
);
	import lcd_bus_pkg::*;

	lcd_cmd_t cmd_q; // held until the next load
	logic e_q;
	logic e_fall;

	assign e_fall = e_q && !e;

	assign pins = '{e: e, rs: cmd_q.rs, rw: cmd_q.rw, data: cmd_q.data};

	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_q <= '0;
			data_oe <= 1'b0;
			e_q <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			e_q <= e;
			if (load) begin
				cmd_q <= cmd;
				data_oe <= !cmd.rw; // release the bus for reads
			end
			rd_valid <= e_fall && cmd_q.rw;
		end
	end

	// panel byte is valid while e falls
	always_ff @(posedge clk) begin
		if (e_fall && cmd_q.rw) rd_data <= lcd_data_in;
	end

endmodule

`default_nettype wire

// ==== hw/lcd_bus_pkg.sv ====
`default_nettype none

package lcd_bus_pkg;

	// one bus cycle as queued by the host
	typedef struct packed {
		logic rs; // register select
		logic rw; // 1 = read
		logic [7:0] data;
	} lcd_cmd_t;

	// values driven toward the panel
	typedef struct packed {
		logic e;
		logic rs;
		logic rw;
		logic [7:0] data;
	} lcd_pins_t;

	// timed steps run by the step timer
	typedef enum logic [2:0] {
		STEP_POWER, // wait only, no enable pulse
		STEP_INIT_SHORT, // function set, display on/off
		STEP_INIT_CLEAR, // display clear
		STEP_INIT_ENTRY, // entry mode set
		STEP_EXEC // host command
	} lcd_step_t;

endpackage

`default_nettype wire

// ==== hw/lcd_cfg_pkg.sv ====
`default_nettype none

package lcd_cfg_pkg;

	// init flags, msb first as in the function set/display/entry commands
	typedef struct packed {
		logic two_line; // N bit of function set
		logic font_5x10; // F bit of function set
		logic display_on; // D
		logic cursor_on; // C
		logic blink_on; // B
		logic increment; // I/D of entry mode
		logic shift; // S of entry mode
	} lcd_init_cfg_t;

endpackage

`default_nettype wire

// ==== hw/lcd_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lcd_consts.svh"

module lcd_cmd_fifo #(
	parameter int DEPTH = `LCD_FIFO_DEPTH
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire lcd_bus_pkg::lcd_cmd_t din,
	input wire logic pop,
	output lcd_bus_pkg::lcd_cmd_t head,
	output logic empty,
	output logic drop
);
	import lcd_bus_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	lcd_cmd_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr, wr_ptr;
	logic [CNT_W-1:0] count;
	logic full, do_push, do_pop;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign do_pop = pop && !empty;
	assign do_push = push && (!full || do_pop); // full + pop frees a slot
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			drop <= 1'b0;
		end else begin
			if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop) count <= count + 1'b1;
			else if (do_pop && !do_push) count <= count - 1'b1;
			drop <= push && !do_push; // one-cycle strobe
		end
	end

endmodule

`default_nettype wire

// ==== hw/lcd_consts.svh ====
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// system clock rate seen by the controller
`define LCD_CYC_PER_US 3

`define LCD_T_POWER_US 500 // panel power-up wait

// init steps pulse e from 0 to LCD_T_INIT_E_US, then hold for the total
`define LCD_T_INIT_E_US 10
`define LCD_T_INIT_SHORT_US 60 // function set, display on/off
`define LCD_T_INIT_CLEAR_US 210 // display clear
`define LCD_T_INIT_ENTRY_US 110 // entry mode set

// host command cycle
`define LCD_T_EXEC_US 50 // whole cycle
`define LCD_T_E_RISE_US 1 // e goes high
`define LCD_T_E_FALL_US 14 // e goes low

// command queue
`define LCD_FIFO_DEPTH 4

`endif

// ==== hw/lcd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl (
	input wire logic clk,
	input wire logic rst,
	input wire lcd_cfg_pkg::lcd_init_cfg_t init_cfg,
	input wire logic fifo_empty,
	input wire lcd_bus_pkg::lcd_cmd_t fifo_head,
	output logic fifo_pop,
	output logic step_start,
	output lcd_bus_pkg::lcd_step_t step,
	input wire logic step_done,
	output logic bus_load,
	output lcd_bus_pkg::lcd_cmd_t bus_cmd,
	output logic init_done
);
	import lcd_cfg_pkg::*;
	import lcd_bus_pkg::*;

	typedef enum logic [2:0] {
		S_POWER,
		S_INIT_FUNC,
		S_INIT_DISP,
		S_INIT_CLEAR,
		S_INIT_ENTRY,
		S_IDLE,
		S_EXEC
	} state_t;

	state_t state, state_nxt;
	logic power_started; // power-up wait already launched
	logic launch; // start a step this cycle
	lcd_init_cfg_t cfg_q;
	lcd_init_cfg_t cfg_use;

	assign cfg_use = (state == S_POWER) ? init_cfg : cfg_q; // live until sampled

	// next step starts in the same cycle the previous one reports done
	always_comb begin
		state_nxt = state;
		launch = 1'b0;
		fifo_pop = 1'b0;
		case (state)
			S_POWER: begin
				if (!power_started) begin
					launch = 1'b1;
				end else if (step_done) begin
					state_nxt = S_INIT_FUNC;
					launch = 1'b1;
				end
			end
			S_INIT_FUNC: begin
				if (step_done) begin
					state_nxt = S_INIT_DISP;
					launch = 1'b1;
				end
			end
			S_INIT_DISP: begin
				if (step_done) begin
					state_nxt = S_INIT_CLEAR;
					launch = 1'b1;
				end
			end
			S_INIT_CLEAR: begin
				if (step_done) begin
					state_nxt = S_INIT_ENTRY;
					launch = 1'b1;
				end
			end
			S_INIT_ENTRY: begin
				if (step_done) state_nxt = S_IDLE;
			end
			S_IDLE: begin
				if (!fifo_empty) begin
					fifo_pop = 1'b1; // head is loaded this same cycle
					state_nxt = S_EXEC;
					launch = 1'b1;
				end
			end
			S_EXEC: begin
				if (step_done) state_nxt = S_IDLE;
			end
			default: state_nxt = S_POWER;
		endcase
	end

	// step kind and command byte for the state being entered
	always_comb begin
		step = STEP_EXEC;
		bus_cmd = fifo_head;
		case (state_nxt)
			S_POWER: step = STEP_POWER;
			S_INIT_FUNC: begin
				step = STEP_INIT_SHORT;
				bus_cmd = '{rs: 1'b0, rw: 1'b0,
					data: {4'b0011, cfg_use.two_line, cfg_use.font_5x10, 2'b00}};
			end
			S_INIT_DISP: begin
				step = STEP_INIT_SHORT;
				bus_cmd = '{rs: 1'b0, rw: 1'b0,
					data: {5'b00001, cfg_use.display_on, cfg_use.cursor_on, cfg_use.blink_on}};
			end
			S_INIT_CLEAR: begin
				step = STEP_INIT_CLEAR;
				bus_cmd = '{rs: 1'b0, rw: 1'b0, data: 8'h01};
			end
			S_INIT_ENTRY: begin
				step = STEP_INIT_ENTRY;
				bus_cmd = '{rs: 1'b0, rw: 1'b0,
					data: {6'b000001, cfg_use.increment, cfg_use.shift}};
			end
			default: ;
		endcase
	end

	assign step_start = launch;
	assign bus_load = launch && (state_nxt != S_POWER); // power step drives no bus

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_POWER;
			power_started <= 1'b0;
			init_done <= 1'b0;
		end else begin
			state <= state_nxt;
			if (launch) power_started <= 1'b1;
			if (state == S_INIT_ENTRY && step_done) init_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_POWER && state_nxt != S_POWER) cfg_q <= init_cfg; // sample on leaving power-up
	end

endmodule

`default_nettype wire

// ==== hw/lcd_step_timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lcd_consts.svh"

module lcd_step_timer (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire lcd_bus_pkg::lcd_step_t step,
	output logic e,
	output logic done
);
	import lcd_bus_pkg::*;

	localparam int POWER_CYC = `LCD_T_POWER_US * `LCD_CYC_PER_US;
	localparam int CNT_W = $clog2(POWER_CYC + 1); // power-up is the longest step

	lcd_step_t step_q;
	logic active;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] total, e_rise, e_fall;

	// windows in cycles, e is high for e_rise <= cnt < e_fall
	always_comb begin
		e_rise = CNT_W'(0);
		e_fall = CNT_W'(`LCD_T_INIT_E_US * `LCD_CYC_PER_US);
		case (step_q)
			STEP_POWER: begin
				total = CNT_W'(POWER_CYC);
				e_fall = CNT_W'(0); // no pulse
			end
			STEP_INIT_SHORT: total = CNT_W'(`LCD_T_INIT_SHORT_US * `LCD_CYC_PER_US);
			STEP_INIT_CLEAR: total = CNT_W'(`LCD_T_INIT_CLEAR_US * `LCD_CYC_PER_US);
			STEP_INIT_ENTRY: total = CNT_W'(`LCD_T_INIT_ENTRY_US * `LCD_CYC_PER_US);
			default: begin
				total = CNT_W'(`LCD_T_EXEC_US * `LCD_CYC_PER_US);
				e_rise = CNT_W'(`LCD_T_E_RISE_US * `LCD_CYC_PER_US);
				e_fall = CNT_W'(`LCD_T_E_FALL_US * `LCD_CYC_PER_US);
			end
		endcase
	end

	assign done = active && (cnt == total - 1'b1);
	assign e = active && (cnt >= e_rise) && (cnt < e_fall);

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			cnt <= '0;
			step_q <= STEP_POWER;
		end else if (start) begin // wins over done for back-to-back steps
			active <= 1'b1;
			cnt <= '0;
			step_q <= step;
		end else if (done) begin
			active <= 1'b0;
		end else if (active) begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/lcd_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lcd_consts.svh"

module lcd_subsys_top (
	input wire logic clk,
	input wire logic rst,
	input wire lcd_cfg_pkg::lcd_init_cfg_t init_cfg,
	input wire logic cmd_push,
	input wire lcd_bus_pkg::lcd_cmd_t cmd,
	output logic cmd_drop,
	output logic rd_valid,
	output logic [7:0] rd_data,
	output logic init_done,
	output lcd_bus_pkg::lcd_pins_t pins,
	output logic data_oe,
	input wire logic [7:0] lcd_data_in
);
	import lcd_bus_pkg::*;

	lcd_cmd_t fifo_head, bus_cmd;
	lcd_step_t step;
	logic fifo_empty, fifo_pop;
	logic step_start, step_done;
	logic bus_load;
	logic e;

	lcd_cmd_fifo #(
		.DEPTH(`LCD_FIFO_DEPTH)
	) u_fifo (
		.clk(clk), .rst(rst),
		.push(cmd_push), .din(cmd),
		.pop(fifo_pop), .head(fifo_head),
		.empty(fifo_empty), .drop(cmd_drop)
	);

	lcd_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.init_cfg(init_cfg),
		.fifo_empty(fifo_empty), .fifo_head(fifo_head), .fifo_pop(fifo_pop),
		.step_start(step_start), .step(step), .step_done(step_done),
		.bus_load(bus_load), .bus_cmd(bus_cmd),
		.init_done(init_done)
	);

	lcd_step_timer u_timer (
		.clk(clk), .rst(rst),
		.start(step_start), .step(step),
		.e(e), .done(step_done)
	);

	lcd_bus_drive u_bus (
		.clk(clk), .rst(rst),
		.load(bus_load), .cmd(bus_cmd),
		.e(e), .lcd_data_in(lcd_data_in),
		.pins(pins), .data_oe(data_oe),
		.rd_valid(rd_valid), .rd_data(rd_data)
	);

endmodule

`default_nettype wire

// ==== verification/lcd_panel_model.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lcd_consts.svh"

module lcd_panel_model (
	input wire logic clk,
	input wire logic rst,
	input wire lcd_bus_pkg::lcd_pins_t pins,
	input wire logic data_oe,
	input wire logic [127:0] rom, // 16 bytes, byte i at bits 8*i+7 .. 8*i
	output logic [7:0] data_out,
	output logic cyc_valid,
	output lcd_bus_pkg::lcd_pins_t cyc_pins,
	output logic cyc_oe,
	output int viol_cnt
);
	import lcd_bus_pkg::*;

	localparam int MIN_E_CYC = `LCD_T_INIT_E_US * `LCD_CYC_PER_US;
	localparam int MIN_GAP_CYC = `LCD_T_EXEC_US * `LCD_CYC_PER_US;

	lcd_pins_t pins_q; // pins as seen one sample earlier
	logic oe_q;
	logic e_q;
	logic seen_rise;
	int high_cnt;
	int gap_cnt;

	// byte addressed by the low data bits, read while rw is high
	assign data_out = rom[{pins.data[3:0], 3'b000} +: 8];

	// sampled mid-cycle, away from the DUT clock edge
	always @(negedge clk) begin
		cyc_valid <= 1'b0;
		if (rst) begin
			e_q <= 1'b0;
			seen_rise <= 1'b0;
			high_cnt <= 0;
			gap_cnt <= 0;
			viol_cnt <= 0;
			pins_q <= '0;
			oe_q <= 1'b0;
			cyc_pins <= '0;
			cyc_oe <= 1'b0;
		end else begin
			e_q <= pins.e;
			pins_q <= pins;
			oe_q <= data_oe;
			gap_cnt <= gap_cnt + 1;
			if (pins.e) high_cnt <= high_cnt + 1;
			if (pins.e && !e_q) begin
				assert (!seen_rise || gap_cnt >= MIN_GAP_CYC) else begin
					$display("Timing error at %0t: enable rose %0d cycles after the last rise",
						$time, gap_cnt);
					viol_cnt <= viol_cnt + 1;
				end
				seen_rise <= 1'b1;
				gap_cnt <= 1;
				high_cnt <= 1;
			end
			if (!pins.e && e_q) begin
				assert (high_cnt >= MIN_E_CYC) else begin
					$display("Timing error at %0t: enable was high for only %0d cycles",
						$time, high_cnt);
					viol_cnt <= viol_cnt + 1;
				end
				cyc_valid <= 1'b1; // one entry per falling enable
				cyc_pins <= pins_q;
				cyc_oe <= oe_q;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/lcd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lcd_consts.svh"

module lcd_tb;
	import lcd_cfg_pkg::*;
	import lcd_bus_pkg::*;

	localparam int DEPTH = `LCD_FIFO_DEPTH;
	localparam int NUM_WR = 12;
	localparam int NUM_RD = 8;

	logic clk;
	logic rst;
	logic cmd_push;
	logic cmd_drop;
	logic rd_valid;
	logic init_done;
	logic data_oe;
	logic cyc_valid;
	logic cyc_oe;
	lcd_init_cfg_t init_cfg;
	lcd_cmd_t cmd;
	lcd_pins_t pins;
	lcd_pins_t cyc_pins;
	logic [7:0] rd_data;
	logic [7:0] lcd_data_in;
	logic [127:0] rom_flat;
	logic [7:0] rom [16]; // reference copy of the panel memory
	int viol_cnt;

	logic [31:0] lfsr = 32'h3741_1c11;
	lcd_pins_t log_pins [$]; // every bus cycle the panel saw
	logic log_oe [$];
	logic [7:0] rd_got [$];
	lcd_cmd_t exp_cmds [$]; // host commands expected at the panel, in order
	logic [7:0] exp_rd [$];
	int drop_cnt = 0;
	int test_errs = 0;
	int total_errs = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic timed_out = 1'b0;

	tb_clk_gen #(.PERIOD_NS(4.0)) u_clk (.clk(clk));

	lcd_panel_model panel (
		.clk(clk), .rst(rst), .pins(pins), .data_oe(data_oe), .rom(rom_flat),
		.data_out(lcd_data_in), .cyc_valid(cyc_valid), .cyc_pins(cyc_pins),
		.cyc_oe(cyc_oe), .viol_cnt(viol_cnt)
	);

	lcd_subsys_top UUT (
		.clk(clk), .rst(rst), .init_cfg(init_cfg),
		.cmd_push(cmd_push), .cmd(cmd), .cmd_drop(cmd_drop),
		.rd_valid(rd_valid), .rd_data(rd_data), .init_done(init_done),
		.pins(pins), .data_oe(data_oe), .lcd_data_in(lcd_data_in)
	);

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	always @(posedge clk) begin // panel entries change on the falling edge
		if (cyc_valid) begin
			log_pins.push_back(cyc_pins);
			log_oe.push_back(cyc_oe);
		end
	end

	always @(negedge clk) begin
		if (!rst && rd_valid) rd_got.push_back(rd_data);
		if (!rst && cmd_drop) drop_cnt++;
	end

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic push_cmd(lcd_cmd_t c);
		cmd = c;
		cmd_push = 1'b1;
		tick();
		cmd_push = 1'b0;
	endtask

	task automatic wait_log(int n, int limit, string what);
		int waited;
		waited = 0;
		while (log_pins.size() < n && !timed_out) begin
			tick();
			waited++;
			if (waited > limit) begin
				$display("Timeout: %s did not reach the panel in %0d cycles", what, limit);
				timed_out = 1'b1;
				test_errs++;
			end
		end
	endtask

	task automatic wait_rd(int n, int limit);
		int waited;
		waited = 0;
		while (rd_got.size() < n && !timed_out) begin
			tick();
			waited++;
			if (waited > limit) begin
				$display("Timeout: read data did not come back in %0d cycles", limit);
				timed_out = 1'b1;
				test_errs++;
			end
		end
	endtask

	task automatic wait_init(int limit);
		int waited;
		waited = 0;
		while (!init_done && !timed_out) begin
			tick();
			waited++;
			if (waited > limit) begin
				$display("Timeout: init_done stayed low for %0d cycles", limit);
				timed_out = 1'b1;
				test_errs++;
			end
		end
	endtask

	task automatic check_cycle(int idx, lcd_cmd_t exp, logic exp_oe);
		lcd_pins_t got;
		got = log_pins[idx];
		assert (got.rs == exp.rs && got.rw == exp.rw && got.data == exp.data
			&& log_oe[idx] == exp_oe) else begin
			$display("Mismatch at %0t: cycle %0d got %b/%b/%h oe=%b, want %b/%b/%h oe=%b",
				$time, idx, got.rs, got.rw, got.data, log_oe[idx],
				exp.rs, exp.rw, exp.data, exp_oe);
			test_errs++;
		end
	endtask

	task automatic report_test(string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_errs);
			tests_failed++;
		end
		total_errs += test_errs;
		test_errs = 0;
	endtask

	initial begin
		lcd_cmd_t c;
		lcd_cmd_t init_exp [4];
		int gap;
		int base;
		rst = 1'b1;
		cmd_push = 1'b0;
		cmd = '0;
		init_cfg = 7'(rand_bits(7));
		for (int i = 0; i < 16; i++) begin
			rom[i] = 8'(rand_bits(8));
			rom_flat[i * 8 +: 8] = rom[i];
		end

		repeat (16) begin
			tick();
			assert (!pins.e && !data_oe && !init_done && !rd_valid && !cmd_drop) else begin
				$display("Mismatch at %0t: output high in reset (e=%b oe=%b done=%b rdv=%b)",
					$time, pins.e, data_oe, init_done, rd_valid);
				test_errs++;
			end
		end
		rst = 1'b0;
		report_test("reset");

		// fill the queue during power-up, the last three pushes fall off
		for (int i = 0; i < DEPTH + 3; i++) begin
			c = '{rs: 1'(rand_bits(1)), rw: 1'b0, data: 8'(rand_bits(8))};
			if (i < DEPTH) exp_cmds.push_back(c);
			push_cmd(c);
		end

		init_exp[0] = '{rs: 1'b0, rw: 1'b0,
			data: 8'h30 | {4'h0, init_cfg.two_line, init_cfg.font_5x10, 2'b00}};
		init_exp[1] = '{rs: 1'b0, rw: 1'b0,
			data: 8'h08 | {5'h00, init_cfg.display_on, init_cfg.cursor_on, init_cfg.blink_on}};
		init_exp[2] = '{rs: 1'b0, rw: 1'b0, data: 8'h01};
		init_exp[3] = '{rs: 1'b0, rw: 1'b0,
			data: 8'h04 | {6'h00, init_cfg.increment, init_cfg.shift}};
		wait_log(1, 2000, "function set");
		init_cfg = ~init_cfg; // already sampled so the remaining init bytes keep the old flags
		wait_log(4, 2000, "init sequence");
		wait_init(1000);
		if (!timed_out) begin
			for (int i = 0; i < 4; i++) check_cycle(i, init_exp[i], 1'b1);
		end
		report_test("init");

		if (!timed_out) begin
			wait_log(4 + DEPTH, DEPTH * 200, "queued commands");
			repeat (400) tick(); // quiet period, nothing more may appear
			if (!timed_out) begin
				assert (drop_cnt == 3 && log_pins.size() == 4 + DEPTH) else begin
					$display("Mismatch at %0t: %0d drops and %0d cycles, want 3 and %0d",
						$time, drop_cnt, log_pins.size(), 4 + DEPTH);
					test_errs++;
				end
				for (int i = 0; i < DEPTH; i++) check_cycle(4 + i, exp_cmds[i], 1'b1);
			end
			report_test("overflow");
		end

		if (!timed_out) begin
			base = log_pins.size();
			for (int i = 0; i < NUM_WR; i++) begin
				gap = 100 + int'(rand_bits(7));
				repeat (gap) tick();
				c = '{rs: 1'(rand_bits(1)), rw: 1'b0, data: 8'(rand_bits(8))};
				exp_cmds.push_back(c);
				push_cmd(c);
			end
			wait_log(base + NUM_WR, 1000, "write commands");
			if (!timed_out) begin
				for (int i = 0; i < NUM_WR; i++) check_cycle(base + i, exp_cmds[DEPTH + i], 1'b1);
				assert (drop_cnt == 3) else begin
					$display("Mismatch at %0t: %0d drops, want 3", $time, drop_cnt);
					test_errs++;
				end
			end
			report_test("writes");
		end

		if (!timed_out) begin
			base = log_pins.size();
			for (int i = 0; i < NUM_RD; i++) begin
				gap = 100 + int'(rand_bits(7));
				repeat (gap) tick();
				c = '{rs: 1'(rand_bits(1)), rw: 1'b1, data: 8'(rand_bits(8))};
				exp_cmds.push_back(c);
				exp_rd.push_back(rom[c.data[3:0]]);
				push_cmd(c);
			end
			wait_rd(NUM_RD, 1500);
			wait_log(base + NUM_RD, 500, "read commands");
			if (!timed_out) begin
				for (int i = 0; i < NUM_RD; i++) begin
					check_cycle(base + i, exp_cmds[DEPTH + NUM_WR + i], 1'b0);
					assert (rd_got[i] == exp_rd[i]) else begin
						$display("Mismatch at %0t: read %0d returned %h, want %h",
							$time, i, rd_got[i], exp_rd[i]);
						test_errs++;
					end
				end
			end
			report_test("reads");
		end

		assert (viol_cnt == 0) else begin
			$display("Mismatch at %0t: panel saw %0d enable timing violations", $time, viol_cnt);
			test_errs++;
		end
		report_test("timing");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
		if (timed_out || tests_failed != 0) begin
			$display("Regression failed");
		end else begin
			$display("Regression passed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD_NS / 2.0) clk = ~clk; // free running, never stops

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/lcd_cfg_pkg.sv
hw/lcd_bus_pkg.sv
hw/lcd_cmd_fifo.sv
hw/lcd_step_timer.sv
hw/lcd_bus_drive.sv
hw/lcd_ctrl.sv
hw/lcd_subsys_top.sv
verification/tb_clk_gen.sv
verification/lcd_panel_model.sv
verification/lcd_tb.sv
